// File: source/core_pkg.sv
package core_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================
    localparam int XLEN        = 32;
    localparam int ISSUE_WIDTH = 3;

    // Instruction, address or data word
    typedef logic [XLEN-1:0] word_t;
    // Architectural register index
    typedef logic [4:0]      reg_addr_t;
    // Push and pop counts, 0 to 3
    typedef logic [1:0]      lane_count_t;
    typedef logic [31:0]     perf_count_t;

    // ========================================================================
    // Decode constants
    // ========================================================================
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // ALU operation, PASS_B forwards the U immediate for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

// File: source/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push_ready_i,
    output word_t inst_addr_0_o,
    output word_t inst_addr_1_o,
    output word_t inst_addr_2_o,
    output word_t pc_0_o,
    output logic  push_valid_o
);

    word_t pc;

    // Three sequential words, answered by memory in the same cycle
    assign inst_addr_0_o = pc;
    assign inst_addr_1_o = pc + 32'd4;
    assign inst_addr_2_o = pc + 32'd8;
    assign pc_0_o        = pc;

    // Push the whole group as soon as the buffer has room for it
    assign push_valid_o = push_ready_i;

    // PC holds while the buffer is short of three free slots
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= RESET_PC;
        end else if (push_valid_o) begin
            pc <= pc + 32'd12;
        end
    end

endmodule

// File: source/instruction_buffer.sv
`timescale 1ns/1ns

module instruction_buffer
    import core_pkg::*;
#(
    parameter  int BUFFER_DEPTH = 16,
    localparam int PTR_W        = $clog2(BUFFER_DEPTH),
    localparam int OCC_W        = PTR_W + 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push_valid_i,
    input  word_t                  instr_0_i,
    input  word_t                  instr_1_i,
    input  word_t                  instr_2_i,
    input  word_t                  pc_0_i,
    input  lane_count_t            pop_count_i,
    output logic                   push_ready_o,
    output logic [ISSUE_WIDTH-1:0] head_valid_o,
    output word_t                  head_instr_0_o,
    output word_t                  head_instr_1_o,
    output word_t                  head_instr_2_o,
    output logic [OCC_W-1:0]       occupancy_o
);

    typedef logic [PTR_W-1:0] ptr_t;

    word_t            instr_mem [BUFFER_DEPTH];
    word_t            pc_mem    [BUFFER_DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    logic [OCC_W-1:0] count;
    word_t            head_pc;

    // Room for a full group of three
    assign push_ready_o = (count <= OCC_W'(BUFFER_DEPTH - ISSUE_WIDTH));
    assign occupancy_o  = count;

    // Heads are contiguous from lane 0
    assign head_valid_o[0] = (count >= OCC_W'(1));
    assign head_valid_o[1] = (count >= OCC_W'(2));
    assign head_valid_o[2] = (count >= OCC_W'(3));

    assign head_instr_0_o = instr_mem[rd_ptr];
    assign head_instr_1_o = instr_mem[rd_ptr + ptr_t'(1)];
    assign head_instr_2_o = instr_mem[rd_ptr + ptr_t'(2)];
    assign head_pc        = pc_mem[rd_ptr];

    // Entry storage, PCs follow from the first word of the group
    always_ff @(posedge clk) begin
        if (push_valid_i) begin
            instr_mem[wr_ptr]              <= instr_0_i;
            instr_mem[wr_ptr + ptr_t'(1)]  <= instr_1_i;
            instr_mem[wr_ptr + ptr_t'(2)]  <= instr_2_i;
            pc_mem[wr_ptr]                 <= pc_0_i;
            pc_mem[wr_ptr + ptr_t'(1)]     <= pc_0_i + 32'd4;
            pc_mem[wr_ptr + ptr_t'(2)]     <= pc_0_i + 32'd8;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr <= wr_ptr + ptr_t'(3);
            end
            rd_ptr <= rd_ptr + ptr_t'(pop_count_i);
            count  <= count + (push_valid_i ? OCC_W'(3) : '0) - OCC_W'(pop_count_i);
        end
    end

    a_push_when_ready: assert property (@(posedge clk) disable iff (!reset)
        push_valid_i |-> push_ready_o);

    a_pop_in_range: assert property (@(posedge clk) disable iff (!reset)
        OCC_W'(pop_count_i) <= count);

    // Entries leave in program order, one word apart
    a_head_pc_order: assert property (@(posedge clk) disable iff (!reset)
        (pop_count_i != 2'd0) && (count > OCC_W'(pop_count_i))
        |=> head_pc == $past(head_pc + (word_t'(pop_count_i) << 2)));

endmodule

// File: source/issue_decode.sv
`timescale 1ns/1ns

module issue_decode
    import core_pkg::*;
(
    input  logic [ISSUE_WIDTH-1:0] head_valid_i,
    input  word_t                  head_instr_0_i,
    input  word_t                  head_instr_1_i,
    input  word_t                  head_instr_2_i,
    output lane_count_t            pop_count_o,
    output reg_addr_t              rs1_0_o, rs2_0_o,
    output reg_addr_t              rs1_1_o, rs2_1_o,
    output reg_addr_t              rs1_2_o, rs2_2_o,
    output logic [ISSUE_WIDTH-1:0] issue_valid_o,
    output reg_addr_t              rd_0_o, rd_1_o, rd_2_o,
    output logic [ISSUE_WIDTH-1:0] reg_write_o,
    output alu_op_e                alu_op_0_o, alu_op_1_o, alu_op_2_o,
    output logic [ISSUE_WIDTH-1:0] use_imm_o,
    output word_t                  imm_0_o, imm_1_o, imm_2_o
);

    word_t                  instr [ISSUE_WIDTH];
    reg_addr_t              rs1   [ISSUE_WIDTH];
    reg_addr_t              rs2   [ISSUE_WIDTH];
    reg_addr_t              rd    [ISSUE_WIDTH];
    alu_op_e                alu_op[ISSUE_WIDTH];
    word_t                  imm   [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] writes;
    logic [ISSUE_WIDTH-1:0] hazard;

    // funct3 picks the operation, bit 30 splits SUB and SRA
    function automatic alu_op_e decode_op(word_t ins);
        if (ins[6:0] == OPCODE_LUI) begin
            return ALU_PASS_B;
        end
        case (ins[14:12])
            3'b000:  return (ins[6:0] == OPCODE_OP && ins[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ins[30] ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr[0] = head_instr_0_i;
    assign instr[1] = head_instr_1_i;
    assign instr[2] = head_instr_2_i;

    // ========================================================================
    // Per-lane field decode
    // ========================================================================
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rs1[k]       = instr[k][19:15];
            rs2[k]       = instr[k][24:20];
            rd[k]        = instr[k][11:7];
            alu_op[k]    = decode_op(instr[k]);
            use_imm_o[k] = (instr[k][6:0] != OPCODE_OP);
            // U immediate for LUI, sign-extended I immediate otherwise
            imm[k] = (instr[k][6:0] == OPCODE_LUI) ? {instr[k][31:12], 12'b0}
                                                  : {{20{instr[k][31]}}, instr[k][31:20]};
            // Unsupported opcodes and rd=0 retire without a write
            writes[k] = (rd[k] != '0) && ((instr[k][6:0] == OPCODE_OP_IMM) ||
                        (instr[k][6:0] == OPCODE_OP) || (instr[k][6:0] == OPCODE_LUI));
        end
    end

    // ========================================================================
    // Intra-group dependencies against earlier nonzero rd
    // ========================================================================
    always_comb begin
        hazard = '0;
        for (int k = 1; k < ISSUE_WIDTH; k++) begin
            for (int j = 0; j < k; j++) begin
                if (rd[j] != '0 && (rs1[k] == rd[j] || rs2[k] == rd[j] ||
                                    (rd[k] != '0 && rd[k] == rd[j]))) begin
                    hazard[k] = 1'b1;
                end
            end
        end
    end

    // In-order group stops at the first blocked lane
    assign issue_valid_o[0] = head_valid_i[0];
    assign issue_valid_o[1] = issue_valid_o[0] && head_valid_i[1] && !hazard[1];
    assign issue_valid_o[2] = issue_valid_o[1] && head_valid_i[2] && !hazard[2];
    assign reg_write_o      = issue_valid_o & writes;
    assign pop_count_o      = lane_count_t'(issue_valid_o[0]) + lane_count_t'(issue_valid_o[1])
                            + lane_count_t'(issue_valid_o[2]);

    assign rs1_0_o = rs1[0];
    assign rs2_0_o = rs2[0];
    assign rs1_1_o = rs1[1];
    assign rs2_1_o = rs2[1];
    assign rs1_2_o = rs1[2];
    assign rs2_2_o = rs2[2];
    assign rd_0_o  = rd[0];
    assign rd_1_o  = rd[1];
    assign rd_2_o  = rd[2];
    assign alu_op_0_o = alu_op[0];
    assign alu_op_1_o = alu_op[1];
    assign alu_op_2_o = alu_op[2];
    assign imm_0_o = imm[0];
    assign imm_1_o = imm[1];
    assign imm_2_o = imm[2];

    // Pop count relies on a gap-free group
    always_comb begin
        a_issue_contiguous: assert (issue_valid_o inside {3'b000, 3'b001, 3'b011, 3'b111});
    end

endmodule

// File: source/alu_lane.sv
`timescale 1ns/1ns

module alu_lane
    import core_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   rs1_data_i,
    input  word_t   rs2_data_i,
    input  word_t   imm_i,
    input  logic    use_imm_i,
    output word_t   result_o
);

    word_t      op_b;
    logic [4:0] shamt;

    // Second operand, immediate for OP-IMM and LUI
    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = rs1_data_i + op_b;
            ALU_SUB:  result_o = rs1_data_i - op_b;
            ALU_SLL:  result_o = rs1_data_i << shamt;
            ALU_SLT:  result_o = word_t'($signed(rs1_data_i) < $signed(op_b));
            ALU_SLTU: result_o = word_t'(rs1_data_i < op_b);
            ALU_XOR:  result_o = rs1_data_i ^ op_b;
            ALU_SRL:  result_o = rs1_data_i >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  result_o = word_t'($signed(rs1_data_i) >>> shamt);
            ALU_OR:   result_o = rs1_data_i | op_b;
            ALU_AND:  result_o = rs1_data_i & op_b;
            default:  result_o = op_b;
        endcase
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns

module register_file
    import core_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  reg_addr_t              rd_addr_0_i, rd_addr_1_i, rd_addr_2_i,
    input  reg_addr_t              rd_addr_3_i, rd_addr_4_i, rd_addr_5_i,
    input  logic [ISSUE_WIDTH-1:0] wr_en_i,
    input  reg_addr_t              wr_addr_0_i, wr_addr_1_i, wr_addr_2_i,
    input  word_t                  wr_data_0_i, wr_data_1_i, wr_data_2_i,
    output word_t                  rd_data_0_o, rd_data_1_o, rd_data_2_o,
    output word_t                  rd_data_3_o, rd_data_4_o, rd_data_5_o
);

    // x1..x31, x0 is decoded away on read
    word_t     regs    [1:31];
    reg_addr_t wr_addr [ISSUE_WIDTH];
    word_t     wr_data [ISSUE_WIDTH];

    assign wr_addr[0] = wr_addr_0_i;
    assign wr_addr[1] = wr_addr_1_i;
    assign wr_addr[2] = wr_addr_2_i;
    assign wr_data[0] = wr_data_0_i;
    assign wr_data[1] = wr_data_1_i;
    assign wr_data[2] = wr_data_2_i;

    // Six combinational read ports
    assign rd_data_0_o = (rd_addr_0_i == '0) ? '0 : regs[rd_addr_0_i];
    assign rd_data_1_o = (rd_addr_1_i == '0) ? '0 : regs[rd_addr_1_i];
    assign rd_data_2_o = (rd_addr_2_i == '0) ? '0 : regs[rd_addr_2_i];
    assign rd_data_3_o = (rd_addr_3_i == '0) ? '0 : regs[rd_addr_3_i];
    assign rd_data_4_o = (rd_addr_4_i == '0) ? '0 : regs[rd_addr_4_i];
    assign rd_data_5_o = (rd_addr_5_i == '0) ? '0 : regs[rd_addr_5_i];

    // Three writes commit on the issue edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (wr_en_i[k] && wr_addr[k] != '0) begin
                    regs[wr_addr[k]] <= wr_data[k];
                end
            end
        end
    end

    // Issue hazard check keeps destinations distinct within a group
    a_write_ports_distinct: assert property (@(posedge clk) disable iff (!reset)
        !(wr_en_i[0] && wr_en_i[1] && wr_addr[0] == wr_addr[1]) &&
        !(wr_en_i[0] && wr_en_i[2] && wr_addr[0] == wr_addr[2]) &&
        !(wr_en_i[1] && wr_en_i[2] && wr_addr[1] == wr_addr[2]));

endmodule

// File: source/perf_counters.sv
`timescale 1ns/1ns

module perf_counters
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        push_valid_i,
    input  logic        push_ready_i,
    input  lane_count_t pop_count_i,
    output perf_count_t perf_cycles_o,
    output perf_count_t perf_fetched_o,
    output perf_count_t perf_retired_o,
    output perf_count_t perf_buffer_stalls_o
);

    // Same edges as the buffer, so fetched = retired + occupancy
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            perf_cycles_o        <= '0;
            perf_fetched_o       <= '0;
            perf_retired_o       <= '0;
            perf_buffer_stalls_o <= '0;
        end else begin
            perf_cycles_o  <= perf_cycles_o + 32'd1;
            perf_retired_o <= perf_retired_o + perf_count_t'(pop_count_i);
            if (push_valid_i) begin
                perf_fetched_o <= perf_fetched_o + 32'd3;
            end
            // Fetch held back by a nearly full buffer
            if (!push_ready_i) begin
                perf_buffer_stalls_o <= perf_buffer_stalls_o + 32'd1;
            end
        end
    end

endmodule

// File: source/superscalar_core.sv
`timescale 1ns/1ns

module superscalar_core
    import core_pkg::*;
#(
    parameter  int    BUFFER_DEPTH = 16,
    parameter  word_t RESET_PC     = '0,
    localparam int    OCC_W        = $clog2(BUFFER_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  word_t                  instruction_0_i, instruction_1_i, instruction_2_i,
    output word_t                  inst_addr_0_o, inst_addr_1_o, inst_addr_2_o,
    output logic [ISSUE_WIDTH-1:0] wb_valid_o,
    output reg_addr_t              wb_rd_0_o, wb_rd_1_o, wb_rd_2_o,
    output word_t                  wb_data_0_o, wb_data_1_o, wb_data_2_o,
    output logic [OCC_W-1:0]       occupancy_o,
    output perf_count_t            perf_cycles_o, perf_fetched_o,
    output perf_count_t            perf_retired_o, perf_buffer_stalls_o
);

    word_t                  pc_0;
    logic                   push_valid;
    logic                   push_ready;
    logic [ISSUE_WIDTH-1:0] head_valid;
    word_t                  head_instr [ISSUE_WIDTH];
    lane_count_t            pop_count;
    logic [ISSUE_WIDTH-1:0] issue_valid;
    logic [ISSUE_WIDTH-1:0] reg_write;
    logic [ISSUE_WIDTH-1:0] use_imm;
    reg_addr_t              rs1 [ISSUE_WIDTH];
    reg_addr_t              rs2 [ISSUE_WIDTH];
    reg_addr_t              rd  [ISSUE_WIDTH];
    alu_op_e                alu_op [ISSUE_WIDTH];
    word_t                  imm [ISSUE_WIDTH];
    word_t                  rs1_data [ISSUE_WIDTH];
    word_t                  rs2_data [ISSUE_WIDTH];
    word_t                  result [ISSUE_WIDTH];

    // ========================================================================
    // Fetch and buffer
    // ========================================================================
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .reset, .push_ready_i(push_ready),
        .inst_addr_0_o, .inst_addr_1_o, .inst_addr_2_o,
        .pc_0_o(pc_0), .push_valid_o(push_valid)
    );

    instruction_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_buffer (
        .clk, .reset, .push_valid_i(push_valid),
        .instr_0_i(instruction_0_i), .instr_1_i(instruction_1_i), .instr_2_i(instruction_2_i),
        .pc_0_i(pc_0), .pop_count_i(pop_count), .push_ready_o(push_ready),
        .head_valid_o(head_valid), .head_instr_0_o(head_instr[0]),
        .head_instr_1_o(head_instr[1]), .head_instr_2_o(head_instr[2]), .occupancy_o
    );

    // ========================================================================
    // Issue, operand read, execute, write-back in one edge
    // ========================================================================
    issue_decode u_issue (
        .head_valid_i(head_valid), .head_instr_0_i(head_instr[0]),
        .head_instr_1_i(head_instr[1]), .head_instr_2_i(head_instr[2]),
        .pop_count_o(pop_count),
        .rs1_0_o(rs1[0]), .rs2_0_o(rs2[0]), .rs1_1_o(rs1[1]), .rs2_1_o(rs2[1]),
        .rs1_2_o(rs1[2]), .rs2_2_o(rs2[2]), .issue_valid_o(issue_valid),
        .rd_0_o(rd[0]), .rd_1_o(rd[1]), .rd_2_o(rd[2]), .reg_write_o(reg_write),
        .alu_op_0_o(alu_op[0]), .alu_op_1_o(alu_op[1]), .alu_op_2_o(alu_op[2]),
        .use_imm_o(use_imm), .imm_0_o(imm[0]), .imm_1_o(imm[1]), .imm_2_o(imm[2])
    );

    register_file u_regs (
        .clk, .reset,
        .rd_addr_0_i(rs1[0]), .rd_addr_1_i(rs2[0]), .rd_addr_2_i(rs1[1]),
        .rd_addr_3_i(rs2[1]), .rd_addr_4_i(rs1[2]), .rd_addr_5_i(rs2[2]),
        .wr_en_i(reg_write), .wr_addr_0_i(rd[0]), .wr_addr_1_i(rd[1]), .wr_addr_2_i(rd[2]),
        .wr_data_0_i(result[0]), .wr_data_1_i(result[1]), .wr_data_2_i(result[2]),
        .rd_data_0_o(rs1_data[0]), .rd_data_1_o(rs2_data[0]), .rd_data_2_o(rs1_data[1]),
        .rd_data_3_o(rs2_data[1]), .rd_data_4_o(rs1_data[2]), .rd_data_5_o(rs2_data[2])
    );

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        alu_lane u_alu (
            .op_i(alu_op[k]), .rs1_data_i(rs1_data[k]), .rs2_data_i(rs2_data[k]),
            .imm_i(imm[k]), .use_imm_i(use_imm[k]), .result_o(result[k])
        );
    end

    perf_counters u_perf (
        .clk, .reset, .push_valid_i(push_valid), .push_ready_i(push_ready),
        .pop_count_i(pop_count), .perf_cycles_o, .perf_fetched_o,
        .perf_retired_o, .perf_buffer_stalls_o
    );

    // ========================================================================
    // Retire trace
    // ========================================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb_valid_o <= '0;
        end else begin
            wb_valid_o <= issue_valid;
        end
    end

    // No-op lanes report rd 0 and data 0
    always_ff @(posedge clk) begin
        wb_rd_0_o   <= reg_write[0] ? rd[0] : '0;
        wb_rd_1_o   <= reg_write[1] ? rd[1] : '0;
        wb_rd_2_o   <= reg_write[2] ? rd[2] : '0;
        wb_data_0_o <= reg_write[0] ? result[0] : '0;
        wb_data_1_o <= reg_write[1] ? result[1] : '0;
        wb_data_2_o <= reg_write[2] ? result[2] : '0;
    end

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Active-low reset, released on a falling edge
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b1;
    end

endmodule

// File: verification/core_checker.sv
`timescale 1ns/1ns

module core_checker
    import core_pkg::*;
#(
    parameter  int BUFFER_DEPTH = 16,
    parameter  int IMEM_WORDS   = 1024,
    localparam int OCC_W        = $clog2(BUFFER_DEPTH) + 1
) (
    input  logic             clk,
    input  logic             reset,
    input  word_t            program_i [IMEM_WORDS],
    input  logic [2:0]       wb_valid_i,
    input  reg_addr_t        wb_rd_0_i, wb_rd_1_i, wb_rd_2_i,
    input  word_t            wb_data_0_i, wb_data_1_i, wb_data_2_i,
    input  logic [OCC_W-1:0] occupancy_i,
    input  perf_count_t      perf_cycles_i, perf_fetched_i,
    input  perf_count_t      perf_retired_i, perf_buffer_stalls_i,
    output int               error_count_o,
    output int               retired_count_o
);

    // Architectural register model with x0 never written
    word_t model_regs [32];
    int    errors       = 0;
    int    next_index   = 0;
    int    lanes_seen   = 0;
    int    cycles_seen  = 0;
    int    stalls_seen  = 0;
    int    fetched_seen = 0;

    assign error_count_o   = errors;
    assign retired_count_o = next_index;

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        errors++;
        $display("FAILED time=%0t ns signal=%s expected=%h actual=%h",
                 $time, name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // ========================================================================
    // Reference model for one RV32I instruction against model_regs
    // ========================================================================
    function automatic word_t reference_result(input word_t ins, output reg_addr_t dest);
        logic [6:0] opcode;
        logic [2:0] funct3;
        word_t      a;
        word_t      b;
        logic [4:0] shamt;
        word_t      r;
        opcode = ins[6:0];
        funct3 = ins[14:12];
        dest   = ins[11:7];
        a      = model_regs[ins[19:15]];
        // rs2 for OP and sign-extended I immediate for OP-IMM
        b      = (opcode == OPCODE_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        shamt  = b[4:0];
        case (funct3)
            3'd0:    r = (opcode == OPCODE_OP && ins[30]) ? a - b : a + b;
            3'd1:    r = a << shamt;
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5: begin
                r = a >> shamt;
                // SRA and SRAI refill the top with the sign bit
                if (ins[30] && a[31]) begin
                    r = r | ~(32'hffff_ffff >> shamt);
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        if (opcode == OPCODE_LUI) begin
            r = {ins[31:12], 12'h000};
        end
        // Everything else retires as a no-op
        if (dest == '0 || !(opcode inside {OPCODE_OP_IMM, OPCODE_OP, OPCODE_LUI})) begin
            dest = '0;
            r    = '0;
        end
        return r;
    endfunction

    // ========================================================================
    // Per-edge comparison of trace and counters
    // ========================================================================
    always @(posedge clk) begin : compare
        reg_addr_t rd_seen   [3];
        word_t     data_seen [3];
        reg_addr_t exp_rd;
        word_t     exp_data;
        rd_seen[0]   = wb_rd_0_i;
        rd_seen[1]   = wb_rd_1_i;
        rd_seen[2]   = wb_rd_2_i;
        data_seen[0] = wb_data_0_i;
        data_seen[1] = wb_data_1_i;
        data_seen[2] = wb_data_2_i;
        if (!reset) begin
            for (int r = 0; r < 32; r++) begin
                model_regs[r] = '0;
            end
            next_index   = 0;
            lanes_seen   = 0;
            cycles_seen  = 0;
            stalls_seen  = 0;
            fetched_seen = 0;
        end else begin
            if (!(wb_valid_i inside {3'b000, 3'b001, 3'b011, 3'b111})) begin
                report_problem("wb_valid_o lanes are not contiguous from lane 0");
            end
            // Lanes retire in program order
            for (int k = 0; k < 3; k++) begin
                if (wb_valid_i[k]) begin
                    if (next_index >= IMEM_WORDS) begin
                        report_problem("instruction retired beyond the end of memory");
                    end else begin
                        exp_data = reference_result(program_i[next_index], exp_rd);
                        if (rd_seen[k] != exp_rd) begin
                            report_mismatch($sformatf("wb_rd_%0d_o", k),
                                            word_t'(exp_rd), word_t'(rd_seen[k]));
                        end
                        if (data_seen[k] != exp_data) begin
                            report_mismatch($sformatf("wb_data_%0d_o", k), exp_data, data_seen[k]);
                        end
                        if (exp_rd != '0) begin
                            model_regs[exp_rd] = exp_data;
                        end
                        next_index++;
                    end
                    lanes_seen++;
                end
            end
            // Counter invariants
            if (perf_retired_i != perf_count_t'(lanes_seen)) begin
                report_mismatch("perf_retired_o", word_t'(lanes_seen), perf_retired_i);
            end
            if (perf_fetched_i % 32'd3 != 32'd0) begin
                report_problem("perf_fetched_o is not a multiple of 3");
            end
            if (perf_fetched_i != perf_count_t'(fetched_seen)) begin
                report_mismatch("perf_fetched_o", word_t'(fetched_seen), perf_fetched_i);
            end
            // Occupancy is what was fetched and not yet retired
            if (perf_count_t'(occupancy_i) != perf_count_t'(fetched_seen - lanes_seen)) begin
                report_mismatch("occupancy_o", word_t'(fetched_seen - lanes_seen),
                                word_t'(occupancy_i));
            end
            if (occupancy_i > OCC_W'(BUFFER_DEPTH)) begin
                report_problem("occupancy_o is above the buffer depth");
            end
            if (perf_cycles_i != perf_count_t'(cycles_seen)) begin
                report_mismatch("perf_cycles_o", word_t'(cycles_seen), perf_cycles_i);
            end
            if (perf_buffer_stalls_i != perf_count_t'(stalls_seen)) begin
                report_mismatch("perf_buffer_stalls_o", word_t'(stalls_seen),
                                perf_buffer_stalls_i);
            end
            cycles_seen++;
            // Three free slots take a whole fetch group
            if (occupancy_i <= OCC_W'(BUFFER_DEPTH - 3)) begin
                fetched_seen += 3;
            end else begin
                // Fewer than three free slots holds fetch
                stalls_seen++;
            end
        end
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ns

module tb_top
    import core_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int BUFFER_DEPTH = 16;
    localparam int OCC_W        = $clog2(BUFFER_DEPTH) + 1;
    localparam int PROG_LEN     = 400;
    localparam int IMEM_WORDS   = 1024;
    // Four cycles per instruction worst case plus slack
    localparam int TIMEOUT_NS   = PROG_LEN * 4 * CLK_PERIOD + 200 * CLK_PERIOD;

    logic             clk;
    logic             reset;
    word_t            instruction_0, instruction_1, instruction_2;
    word_t            inst_addr_0, inst_addr_1, inst_addr_2;
    logic [2:0]       wb_valid;
    reg_addr_t        wb_rd_0, wb_rd_1, wb_rd_2;
    word_t            wb_data_0, wb_data_1, wb_data_2;
    logic [OCC_W-1:0] occupancy;
    perf_count_t      perf_cycles, perf_fetched, perf_retired, perf_buffer_stalls;
    word_t            imem [IMEM_WORDS];
    int               error_count;
    int               retired_count;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clock (.clk_o(clk), .reset_o(reset));

    superscalar_core #(.BUFFER_DEPTH(BUFFER_DEPTH), .RESET_PC('0)) dut (
        .clk(clk), .reset(reset),
        .instruction_0_i(instruction_0), .instruction_1_i(instruction_1),
        .instruction_2_i(instruction_2),
        .inst_addr_0_o(inst_addr_0), .inst_addr_1_o(inst_addr_1), .inst_addr_2_o(inst_addr_2),
        .wb_valid_o(wb_valid), .wb_rd_0_o(wb_rd_0), .wb_rd_1_o(wb_rd_1), .wb_rd_2_o(wb_rd_2),
        .wb_data_0_o(wb_data_0), .wb_data_1_o(wb_data_1), .wb_data_2_o(wb_data_2),
        .occupancy_o(occupancy), .perf_cycles_o(perf_cycles), .perf_fetched_o(perf_fetched),
        .perf_retired_o(perf_retired), .perf_buffer_stalls_o(perf_buffer_stalls)
    );

    core_checker #(.BUFFER_DEPTH(BUFFER_DEPTH), .IMEM_WORDS(IMEM_WORDS)) u_checker (
        .clk(clk), .reset(reset), .program_i(imem), .wb_valid_i(wb_valid),
        .wb_rd_0_i(wb_rd_0), .wb_rd_1_i(wb_rd_1), .wb_rd_2_i(wb_rd_2),
        .wb_data_0_i(wb_data_0), .wb_data_1_i(wb_data_1), .wb_data_2_i(wb_data_2),
        .occupancy_i(occupancy), .perf_cycles_i(perf_cycles), .perf_fetched_i(perf_fetched),
        .perf_retired_i(perf_retired), .perf_buffer_stalls_i(perf_buffer_stalls),
        .error_count_o(error_count), .retired_count_o(retired_count)
    );

    // ========================================================================
    // Program generation, registers x0..x7 for frequent dependencies
    // ========================================================================
    function automatic word_t random_instr();
        int         kind;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [2:0] funct3;
        logic [11:0] imm;
        logic [6:0] funct7;
        logic [6:0] opcode;
        kind   = int'($urandom_range(15, 0));
        rd     = reg_addr_t'($urandom_range(7, 0));
        rs1    = reg_addr_t'($urandom_range(7, 0));
        rs2    = reg_addr_t'($urandom_range(7, 0));
        funct3 = 3'($urandom_range(7, 0));
        imm    = 12'($urandom);
        funct7 = 7'b0000000;
        if (kind == 0) begin
            // Load, store, branch, AUIPC
            case ($urandom_range(3, 0))
                0:       opcode = 7'b0000011;
                1:       opcode = 7'b0100011;
                2:       opcode = 7'b1100011;
                default: opcode = 7'b0010111;
            endcase
            return {25'($urandom), opcode};
        end else if (kind <= 2) begin
            return {20'($urandom), rd, OPCODE_LUI};
        end else if (kind <= 8) begin
            // Shift immediates carry funct7 in imm[11:5]
            if (funct3 == 3'b001) begin
                imm[11:5] = 7'b0000000;
            end
            if (funct3 == 3'b101) begin
                imm[11:5] = ($urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0000000;
            end
            return {imm, rs1, funct3, rd, OPCODE_OP_IMM};
        end
        if (funct3 == 3'b000 || funct3 == 3'b101) begin
            funct7 = ($urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0000000;
        end
        return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
    endfunction

    // Memory answers the current fetch addresses on the falling edge
    always @(negedge clk) begin
        instruction_0 <= imem[inst_addr_0[11:2]];
        instruction_1 <= imem[inst_addr_1[11:2]];
        instruction_2 <= imem[inst_addr_2[11:2]];
    end

    initial begin
        instruction_0 = '0;
        instruction_1 = '0;
        instruction_2 = '0;
        void'($urandom(32'h9e529809));
        // Tail is ADDI x0 with the word index as immediate
        for (int i = 0; i < IMEM_WORDS; i++) begin
            if (i < PROG_LEN) begin
                imem[i] = random_instr();
            end else begin
                imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, OPCODE_OP_IMM};
            end
        end
        wait (retired_count >= PROG_LEN);
        repeat (2) @(negedge clk);
        $display("Run complete: %0d errors, %0d instructions retired",
                 error_count, retired_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns: %0d errors, %0d of %0d instructions retired",
                 TIMEOUT_NS, error_count, retired_count, PROG_LEN);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: flist.f
source/core_pkg.sv
source/fetch_unit.sv
source/instruction_buffer.sv
source/issue_decode.sv
source/alu_lane.sv
source/register_file.sv
source/perf_counters.sv
source/superscalar_core.sv
verification/clock_gen.sv
verification/core_checker.sv
verification/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
